//--- tia_pkg.sv
// Shared types, sizes and register map of the TIA video core, imported by every RTL module
package tia_pkg;

  typedef logic [6:0] color_t;  // Luminance and hue
  typedef logic [7:0] xpos_t;   // 0 to 227
  typedef logic [8:0] ypos_t;   // Line number
  typedef logic [5:0] addr_t;
  typedef logic [7:0] data_t;

  localparam int HLINE_CLOCKS  = 228;  // Colour clocks per line
  localparam int VISIBLE_WIDTH = 160;  // First hblank position
  localparam int RESET_OFFSET  = 5;    // Delay added to RESxx
  localparam int PF_WIDTH      = 20;

  // Write addresses
  localparam addr_t VSYNC  = 6'h00;
  localparam addr_t VBLANK = 6'h01;
  localparam addr_t WSYNC  = 6'h02;
  localparam addr_t NUSIZ0 = 6'h04;
  localparam addr_t NUSIZ1 = 6'h05;
  localparam addr_t COLUP0 = 6'h06;
  localparam addr_t COLUP1 = 6'h07;
  localparam addr_t COLUPF = 6'h08;
  localparam addr_t COLUBK = 6'h09;
  localparam addr_t CTRLPF = 6'h0a;
  localparam addr_t REFP0  = 6'h0b;
  localparam addr_t REFP1  = 6'h0c;
  localparam addr_t PF0    = 6'h0d;
  localparam addr_t PF1    = 6'h0e;
  localparam addr_t PF2    = 6'h0f;
  localparam addr_t RESP0  = 6'h10;
  localparam addr_t RESP1  = 6'h11;
  localparam addr_t RESM0  = 6'h12;
  localparam addr_t RESM1  = 6'h13;
  localparam addr_t RESBL  = 6'h14;
  localparam addr_t GRP0   = 6'h1b;
  localparam addr_t GRP1   = 6'h1c;
  localparam addr_t ENAM0  = 6'h1d;
  localparam addr_t ENAM1  = 6'h1e;
  localparam addr_t ENABL  = 6'h1f;
  localparam addr_t HMP0   = 6'h20;
  localparam addr_t HMP1   = 6'h21;
  localparam addr_t HMM0   = 6'h22;
  localparam addr_t HMM1   = 6'h23;
  localparam addr_t HMBL   = 6'h24;
  localparam addr_t HMOVE  = 6'h2a;
  localparam addr_t HMCLR  = 6'h2b;
  localparam addr_t CXCLR  = 6'h2c;

  // Collision latch bit positions, read back in pairs
  localparam int CX_M0P1 = 14;
  localparam int CX_M0P0 = 13;
  localparam int CX_M1P0 = 12;
  localparam int CX_M1P1 = 11;
  localparam int CX_P0PF = 10;
  localparam int CX_P0BL = 9;
  localparam int CX_P1PF = 8;
  localparam int CX_P1BL = 7;
  localparam int CX_M0PF = 6;
  localparam int CX_M0BL = 5;
  localparam int CX_M1PF = 4;
  localparam int CX_M1BL = 3;
  localparam int CX_BLPF = 2;
  localparam int CX_P0P1 = 1;
  localparam int CX_M0M1 = 0;

endpackage

//--- tia_regs.sv
// CPU-side register file of the TIA: write decode, WSYNC stall, HMOVE motion and read-back
module tia_regs import tia_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                stb_i,
  input  logic                we_i,
  input  addr_t               adr_i,
  input  data_t               dat_i,
  input  xpos_t               beam_x_i,
  input  logic [14:0]         cx_i,
  output data_t               dat_o,
  output logic                stall_o,
  output logic                vsync_o,
  output logic                vblank_o,
  output logic                vsync_start_o,
  output logic [PF_WIDTH-1:0] pf_o,
  output logic                pf_reflect_o,
  output logic                score_o,
  output logic                pf_priority_o,
  output data_t               grp0_o,
  output data_t               grp1_o,
  output logic [5:0]          p0_w_o,
  output logic [5:0]          p1_w_o,
  output logic [1:0]          p0_copies_o,
  output logic [1:0]          p1_copies_o,
  output logic [6:0]          p0_spacing_o,
  output logic [6:0]          p1_spacing_o,
  output logic [1:0]          p0_scale_o,
  output logic [1:0]          p1_scale_o,
  output logic                refp0_o,
  output logic                refp1_o,
  output xpos_t               x_p0_o,
  output xpos_t               x_p1_o,
  output xpos_t               x_m0_o,
  output xpos_t               x_m1_o,
  output xpos_t               x_bl_o,
  output logic [3:0]          m0_w_o,
  output logic [3:0]          m1_w_o,
  output logic [3:0]          bl_w_o,
  output logic                enam0_o,
  output logic                enam1_o,
  output logic                enabl_o,
  output color_t              colup0_o,
  output color_t              colup1_o,
  output color_t              colupf_o,
  output color_t              colubk_o,
  output logic                cx_clr_o
);

  typedef struct packed {
    logic [5:0] width;
    logic [1:0] copies;
    logic [6:0] spacing;
    logic [1:0] scale;
  } player_size_t;

  // NUSIZ player field to width, copies, spacing and scale
  function automatic player_size_t decode_nusiz(logic [2:0] mode);
    player_size_t s;
    case (mode)
      3'd1:    s = '{6'd8, 2'd1, 7'd16, 2'd0};
      3'd2:    s = '{6'd8, 2'd1, 7'd32, 2'd0};
      3'd3:    s = '{6'd8, 2'd2, 7'd16, 2'd0};
      3'd4:    s = '{6'd8, 2'd1, 7'd64, 2'd0};
      3'd5:    s = '{6'd16, 2'd0, 7'd0, 2'd1};  // Double size
      3'd6:    s = '{6'd8, 2'd2, 7'd32, 2'd0};
      3'd7:    s = '{6'd32, 2'd0, 7'd0, 2'd2};  // Quad size
      default: s = '{6'd8, 2'd0, 7'd0, 2'd0};
    endcase
    return s;
  endfunction

  // Signed motion nibble, sign extended to a position step
  function automatic xpos_t motion(logic [3:0] nib);
    return {{4{nib[3]}}, nib};
  endfunction

  logic       wr;
  logic       rd;
  xpos_t      res_pos;
  logic [4:0] nusiz0_q, nusiz1_q;      // {missile size, player mode}
  logic [1:0] bl_size_q;
  logic [3:0] hmp0_q, hmp1_q, hmm0_q, hmm1_q, hmbl_q;

  assign wr = stb_i && we_i;
  assign rd = stb_i && !we_i;
  assign res_pos = (beam_x_i >= VISIBLE_WIDTH) ? '0 : beam_x_i + xpos_t'(RESET_OFFSET);
  assign vsync_start_o = wr && adr_i == VSYNC && dat_i[1] && !vsync_o;

  assign {p0_w_o, p0_copies_o, p0_spacing_o, p0_scale_o} = decode_nusiz(nusiz0_q[2:0]);
  assign {p1_w_o, p1_copies_o, p1_spacing_o, p1_scale_o} = decode_nusiz(nusiz1_q[2:0]);
  assign m0_w_o = 4'(1 << nusiz0_q[4:3]);
  assign m1_w_o = 4'(1 << nusiz1_q[4:3]);
  assign bl_w_o = 4'(1 << bl_size_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      {vsync_o, vblank_o, stall_o, cx_clr_o} <= '0;
      {pf_o, pf_reflect_o, score_o, pf_priority_o, bl_size_q} <= '0;
      {nusiz0_q, nusiz1_q, refp0_o, refp1_o, grp0_o, grp1_o} <= '0;
      {enam0_o, enam1_o, enabl_o} <= '0;
      {x_p0_o, x_p1_o, x_m0_o, x_m1_o, x_bl_o} <= '0;
      {hmp0_q, hmp1_q, hmm0_q, hmm1_q, hmbl_q} <= '0;
      {colup0_o, colup1_o, colupf_o, colubk_o} <= '0;
      dat_o <= '0;
    end else begin
      cx_clr_o <= wr && adr_i == CXCLR;
      if (beam_x_i == xpos_t'(VISIBLE_WIDTH)) stall_o <= 1'b0;  // Release at hblank
      if (wr) begin
        case (adr_i)
          VSYNC:  vsync_o <= dat_i[1];
          VBLANK: vblank_o <= dat_i[1];
          WSYNC:  stall_o <= 1'b1;
          NUSIZ0: nusiz0_q <= {dat_i[5:4], dat_i[2:0]};
          NUSIZ1: nusiz1_q <= {dat_i[5:4], dat_i[2:0]};
          COLUP0: colup0_o <= dat_i[7:1];
          COLUP1: colup1_o <= dat_i[7:1];
          COLUPF: colupf_o <= dat_i[7:1];
          COLUBK: colubk_o <= dat_i[7:1];
          CTRLPF: begin
            pf_reflect_o  <= dat_i[0];
            score_o       <= dat_i[1];
            pf_priority_o <= dat_i[2];
            bl_size_q     <= dat_i[5:4];
          end
          REFP0:  refp0_o <= dat_i[3];
          REFP1:  refp1_o <= dat_i[3];
          PF0:    pf_o[3:0] <= dat_i[7:4];
          PF1:    pf_o[11:4] <= {<<{dat_i}};  // Drawn MSB first
          PF2:    pf_o[19:12] <= dat_i;
          RESP0:  x_p0_o <= res_pos;
          RESP1:  x_p1_o <= res_pos;
          RESM0:  x_m0_o <= res_pos;
          RESM1:  x_m1_o <= res_pos;
          RESBL:  x_bl_o <= res_pos;
          GRP0:   grp0_o <= dat_i;
          GRP1:   grp1_o <= dat_i;
          ENAM0:  enam0_o <= dat_i[1];
          ENAM1:  enam1_o <= dat_i[1];
          ENABL:  enabl_o <= dat_i[1];
          HMP0:   hmp0_q <= dat_i[7:4];
          HMP1:   hmp1_q <= dat_i[7:4];
          HMM0:   hmm0_q <= dat_i[7:4];
          HMM1:   hmm1_q <= dat_i[7:4];
          HMBL:   hmbl_q <= dat_i[7:4];
          HMOVE: begin  // Positive nibble moves left
            x_p0_o <= x_p0_o - motion(hmp0_q);
            x_p1_o <= x_p1_o - motion(hmp1_q);
            x_m0_o <= x_m0_o - motion(hmm0_q);
            x_m1_o <= x_m1_o - motion(hmm1_q);
            x_bl_o <= x_bl_o - motion(hmbl_q);
          end
          HMCLR:  {hmp0_q, hmp1_q, hmm0_q, hmm1_q, hmbl_q} <= '0;
          default: ;
        endcase
      end
      if (rd) begin
        dat_o <= '0;  // Input ports read as zero
        if (adr_i[5:3] == 3'd0) begin
          case (adr_i[2:0])
            3'd0: dat_o <= {cx_i[14:13], 6'd0};
            3'd1: dat_o <= {cx_i[12:11], 6'd0};
            3'd2: dat_o <= {cx_i[10:9], 6'd0};
            3'd3: dat_o <= {cx_i[8:7], 6'd0};
            3'd4: dat_o <= {cx_i[6:5], 6'd0};
            3'd5: dat_o <= {cx_i[4:3], 6'd0};
            3'd6: dat_o <= {cx_i[2], 7'd0};  // CXBLPF has one bit
            3'd7: dat_o <= {cx_i[1:0], 6'd0};
            default: ;
          endcase
        end
      end
    end
  end

endmodule

//--- tia_beam.sv
// Beam position counters of the TIA, one colour clock per cycle, restarted by VSYNC
module tia_beam import tia_pkg::*; #(
  parameter int LINES_PER_FRAME = 262
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  vsync_start_i,
  output xpos_t beam_x_o,
  output ypos_t beam_y_o
);

  localparam xpos_t LAST_X = xpos_t'(HLINE_CLOCKS - 1);
  localparam ypos_t LAST_Y = ypos_t'(LINES_PER_FRAME - 1);

  always_ff @(posedge clk) begin
    if (reset || vsync_start_i) begin
      beam_x_o <= '0;
      beam_y_o <= '0;
    end else if (beam_y_o < LAST_Y) begin
      if (beam_x_o == LAST_X) begin  // End of line
        beam_x_o <= '0;
        beam_y_o <= beam_y_o + 1'b1;
      end else begin
        beam_x_o <= beam_x_o + 1'b1;
      end
    end else begin
      beam_y_o <= '0;  // Frame wrap, x holds
    end
  end

endmodule

//--- tia_objects.sv
// Object stage of the TIA: computes playfield, player, missile and ball hits for each beam position
module tia_objects import tia_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  xpos_t               beam_x_i,
  input  ypos_t               beam_y_i,
  input  logic [PF_WIDTH-1:0] pf_i,
  input  logic                pf_reflect_i,
  input  data_t               grp0_i,
  input  data_t               grp1_i,
  input  logic [5:0]          p0_w_i,
  input  logic [5:0]          p1_w_i,
  input  logic [1:0]          p0_copies_i,
  input  logic [1:0]          p1_copies_i,
  input  logic [6:0]          p0_spacing_i,
  input  logic [6:0]          p1_spacing_i,
  input  logic [1:0]          p0_scale_i,
  input  logic [1:0]          p1_scale_i,
  input  logic                refp0_i,
  input  logic                refp1_i,
  input  xpos_t               x_p0_i,
  input  xpos_t               x_p1_i,
  input  xpos_t               x_m0_i,
  input  xpos_t               x_m1_i,
  input  xpos_t               x_bl_i,
  input  logic [3:0]          m0_w_i,
  input  logic [3:0]          m1_w_i,
  input  logic [3:0]          bl_w_i,
  input  logic                enam0_i,
  input  logic                enam1_i,
  input  logic                enabl_i,
  output logic                pf_o,
  output logic                p0_o,
  output logic                p1_o,
  output logic                m0_o,
  output logic                m1_o,
  output logic                bl_o,
  output xpos_t               pix_x_o,
  output ypos_t               pix_y_o
);

  // Player pixel, checking the main copy and then the spaced copies
  function automatic logic player_hit(xpos_t x, xpos_t pos, data_t grp, logic [5:0] w,
                                      logic [1:0] copies, logic [6:0] spacing,
                                      logic [1:0] scale, logic refl);
    xpos_t      off;
    xpos_t      off1;
    xpos_t      off2;
    logic       hit;
    logic [2:0] idx;
    off  = x - pos;
    off1 = off - xpos_t'(spacing);
    off2 = off - {spacing, 1'b0};
    hit  = off < xpos_t'(w);
    if (!hit && copies != 2'd0 && off1 < xpos_t'(w)) begin
      off = off1;
      hit = 1'b1;
    end else if (!hit && copies == 2'd2 && off2 < xpos_t'(w)) begin
      off = off2;
      hit = 1'b1;
    end
    idx = 3'(off >> scale);
    return hit && (refl ? grp[idx] : grp[3'd7 - idx]);
  endfunction

  // Missile and ball span
  function automatic logic in_span(xpos_t x, xpos_t pos, logic [3:0] w);
    return xpos_t'(x - pos) < xpos_t'(w);
  endfunction

  xpos_t      pf_col;
  logic [4:0] pf_idx;
  logic       pf_hit;

  always_comb begin
    if (beam_x_i < xpos_t'(VISIBLE_WIDTH / 2))
      pf_col = beam_x_i;
    else if (pf_reflect_i)
      pf_col = xpos_t'(VISIBLE_WIDTH - 1) - beam_x_i;  // Mirrored right half
    else
      pf_col = beam_x_i - xpos_t'(VISIBLE_WIDTH / 2);
    pf_idx = pf_col[6:2];
    pf_hit = beam_x_i < xpos_t'(VISIBLE_WIDTH) && pf_idx < 5'(PF_WIDTH) && pf_i[pf_idx];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {pf_o, p0_o, p1_o, m0_o, m1_o, bl_o} <= '0;
      pix_x_o <= '0;
      pix_y_o <= '0;
    end else begin
      pf_o <= pf_hit;
      p0_o <= player_hit(beam_x_i, x_p0_i, grp0_i, p0_w_i, p0_copies_i, p0_spacing_i,
                         p0_scale_i, refp0_i);
      p1_o <= player_hit(beam_x_i, x_p1_i, grp1_i, p1_w_i, p1_copies_i, p1_spacing_i,
                         p1_scale_i, refp1_i);
      m0_o <= enam0_i && in_span(beam_x_i, x_m0_i, m0_w_i);
      m1_o <= enam1_i && in_span(beam_x_i, x_m1_i, m1_w_i);
      bl_o <= enabl_i && in_span(beam_x_i, x_bl_i, bl_w_i);
      pix_x_o <= beam_x_i;
      pix_y_o <= beam_y_i;
    end
  end

endmodule

//--- tia_mixer.sv
// Pixel mixer of the TIA: colour priority, video write strobe and the collision latches
module tia_mixer import tia_pkg::*; #(
  parameter int FIRST_VISIBLE_LINE = 22
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        pf_i,
  input  logic        p0_i,
  input  logic        p1_i,
  input  logic        m0_i,
  input  logic        m1_i,
  input  logic        bl_i,
  input  xpos_t       pix_x_i,
  input  ypos_t       pix_y_i,
  input  color_t      colup0_i,
  input  color_t      colup1_i,
  input  color_t      colupf_i,
  input  color_t      colubk_i,
  input  logic        score_i,
  input  logic        pf_priority_i,
  input  logic        cx_clr_i,
  output logic [14:0] cx_o,
  output logic        vid_wr_o,
  output xpos_t       vid_x_o,
  output ypos_t       vid_y_o,
  output color_t      vid_color_o
);

  logic        visible_x;
  color_t      pf_color;
  color_t      color;
  logic [14:0] cx_set;

  assign visible_x = pix_x_i < xpos_t'(VISIBLE_WIDTH);

  // Score mode paints each half with its player's colour
  assign pf_color = !score_i ? colupf_i :
                    (pix_x_i < xpos_t'(VISIBLE_WIDTH / 2)) ? colup0_i : colup1_i;

  always_comb begin
    if (bl_i)                      color = colupf_i;
    else if (m0_i)                 color = colup0_i;
    else if (m1_i)                 color = colup1_i;
    else if (pf_priority_i && pf_i) color = pf_color;
    else if (p0_i)                 color = colup0_i;
    else if (p1_i)                 color = colup1_i;
    else if (pf_i)                 color = pf_color;
    else                           color = colubk_i;
  end

  always_comb begin
    cx_set          = '0;
    cx_set[CX_M0P1] = m0_i && p1_i;
    cx_set[CX_M0P0] = m0_i && p0_i;
    cx_set[CX_M1P0] = m1_i && p0_i;
    cx_set[CX_M1P1] = m1_i && p1_i;
    cx_set[CX_P0PF] = p0_i && pf_i;
    cx_set[CX_P0BL] = p0_i && bl_i;
    cx_set[CX_P1PF] = p1_i && pf_i;
    cx_set[CX_P1BL] = p1_i && bl_i;
    cx_set[CX_M0PF] = m0_i && pf_i;
    cx_set[CX_M0BL] = m0_i && bl_i;
    cx_set[CX_M1PF] = m1_i && pf_i;
    cx_set[CX_M1BL] = m1_i && bl_i;
    cx_set[CX_BLPF] = bl_i && pf_i;
    cx_set[CX_P0P1] = p0_i && p1_i;
    cx_set[CX_M0M1] = m0_i && m1_i;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cx_o     <= '0;
      vid_wr_o <= 1'b0;
    end else begin
      if (cx_clr_i) cx_o <= '0;  // Clear wins over set
      else if (visible_x) cx_o <= cx_o | cx_set;
      vid_wr_o <= visible_x && pix_y_i >= ypos_t'(FIRST_VISIBLE_LINE);
    end
  end

  always_ff @(posedge clk) begin
    vid_x_o     <= pix_x_i;
    vid_y_o     <= pix_y_i;
    vid_color_o <= color;
  end

endmodule

//--- tia_top.sv
// Top level of the TIA video core, chaining register file, beam counter, objects and mixer
module tia_top import tia_pkg::*; #(
  parameter int LINES_PER_FRAME    = 262,
  parameter int FIRST_VISIBLE_LINE = 22
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   stb_i,
  input  logic   we_i,
  input  addr_t  adr_i,
  input  data_t  dat_i,
  output data_t  dat_o,
  output logic   stall_o,
  output logic   vid_vsync_o,
  output logic   vid_vblank_o,
  output logic   vid_wr_o,
  output xpos_t  vid_x_o,
  output ypos_t  vid_y_o,
  output color_t vid_color_o
);

  logic                vsync_start, cx_clr, score, pf_priority, pf_reflect;
  xpos_t               beam_x, pix_x;
  ypos_t               beam_y, pix_y;
  logic [14:0]         cx;
  logic [PF_WIDTH-1:0] pf;
  data_t               grp0, grp1;
  logic [5:0]          p0_w, p1_w;
  logic [1:0]          p0_copies, p1_copies, p0_scale, p1_scale;
  logic [6:0]          p0_spacing, p1_spacing;
  logic                refp0, refp1, enam0, enam1, enabl;
  xpos_t               x_p0, x_p1, x_m0, x_m1, x_bl;
  logic [3:0]          m0_w, m1_w, bl_w;
  color_t              colup0, colup1, colupf, colubk;
  logic                pf_hit, p0_hit, p1_hit, m0_hit, m1_hit, bl_hit;

  tia_regs u_regs (
    .clk, .reset, .stb_i, .we_i, .adr_i, .dat_i, .beam_x_i(beam_x), .cx_i(cx),
    .dat_o, .stall_o, .vsync_o(vid_vsync_o), .vblank_o(vid_vblank_o),
    .vsync_start_o(vsync_start), .pf_o(pf), .pf_reflect_o(pf_reflect), .score_o(score),
    .pf_priority_o(pf_priority), .grp0_o(grp0), .grp1_o(grp1), .p0_w_o(p0_w), .p1_w_o(p1_w),
    .p0_copies_o(p0_copies), .p1_copies_o(p1_copies), .p0_spacing_o(p0_spacing),
    .p1_spacing_o(p1_spacing), .p0_scale_o(p0_scale), .p1_scale_o(p1_scale),
    .refp0_o(refp0), .refp1_o(refp1), .x_p0_o(x_p0), .x_p1_o(x_p1), .x_m0_o(x_m0),
    .x_m1_o(x_m1), .x_bl_o(x_bl), .m0_w_o(m0_w), .m1_w_o(m1_w), .bl_w_o(bl_w),
    .enam0_o(enam0), .enam1_o(enam1), .enabl_o(enabl), .colup0_o(colup0),
    .colup1_o(colup1), .colupf_o(colupf), .colubk_o(colubk), .cx_clr_o(cx_clr)
  );

  tia_beam #(.LINES_PER_FRAME(LINES_PER_FRAME)) u_beam (
    .clk, .reset, .vsync_start_i(vsync_start), .beam_x_o(beam_x), .beam_y_o(beam_y)
  );

  tia_objects u_objects (
    .clk, .reset, .beam_x_i(beam_x), .beam_y_i(beam_y), .pf_i(pf), .pf_reflect_i(pf_reflect),
    .grp0_i(grp0), .grp1_i(grp1), .p0_w_i(p0_w), .p1_w_i(p1_w), .p0_copies_i(p0_copies),
    .p1_copies_i(p1_copies), .p0_spacing_i(p0_spacing), .p1_spacing_i(p1_spacing),
    .p0_scale_i(p0_scale), .p1_scale_i(p1_scale), .refp0_i(refp0), .refp1_i(refp1),
    .x_p0_i(x_p0), .x_p1_i(x_p1), .x_m0_i(x_m0), .x_m1_i(x_m1), .x_bl_i(x_bl),
    .m0_w_i(m0_w), .m1_w_i(m1_w), .bl_w_i(bl_w), .enam0_i(enam0), .enam1_i(enam1),
    .enabl_i(enabl), .pf_o(pf_hit), .p0_o(p0_hit), .p1_o(p1_hit), .m0_o(m0_hit),
    .m1_o(m1_hit), .bl_o(bl_hit), .pix_x_o(pix_x), .pix_y_o(pix_y)
  );

  tia_mixer #(.FIRST_VISIBLE_LINE(FIRST_VISIBLE_LINE)) u_mixer (
    .clk, .reset, .pf_i(pf_hit), .p0_i(p0_hit), .p1_i(p1_hit), .m0_i(m0_hit), .m1_i(m1_hit),
    .bl_i(bl_hit), .pix_x_i(pix_x), .pix_y_i(pix_y), .colup0_i(colup0), .colup1_i(colup1),
    .colupf_i(colupf), .colubk_i(colubk), .score_i(score), .pf_priority_i(pf_priority),
    .cx_clr_i(cx_clr), .cx_o(cx), .vid_wr_o, .vid_x_o, .vid_y_o, .vid_color_o
  );

endmodule

//--- tia_assert.sv
// Concurrent timing checks on the TIA top level, bound into tia_top
module tia_assert import tia_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  stb_i,
  input logic  we_i,
  input addr_t adr_i,
  input logic  stall_o,
  input logic  vid_wr_o,
  input xpos_t vid_x_o,
  input ypos_t vid_y_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  strobe_visible: assert property (@(posedge clk) disable iff (reset)
    vid_wr_o |-> vid_x_o < xpos_t'(VISIBLE_WIDTH))
    else begin fail_count++; $error("vid_wr_o outside the visible width"); end

  stall_after_wsync: assert property (@(posedge clk) disable iff (reset)
    $rose(stall_o) |-> $past(stb_i && we_i && adr_i == WSYNC))
    else begin fail_count++; $error("stall_o rose without a WSYNC write"); end

  // Consecutive strobes on one line step x by one
  pixel_step: assert property (@(posedge clk) disable iff (reset)
    vid_wr_o && $past(vid_wr_o) && vid_y_o == $past(vid_y_o)
      |-> vid_x_o == xpos_t'($past(vid_x_o) + 8'd1))
    else begin fail_count++; $error("vid_x_o did not advance by one"); end

endmodule

bind tia_top tia_assert u_assert (
  .clk(clk), .reset(reset), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .stall_o(stall_o),
  .vid_wr_o(vid_wr_o), .vid_x_o(vid_x_o), .vid_y_o(vid_y_o)
);

//--- tb_tia.sv
// Testbench that replays the stimulus file on the TIA CPU bus and checks its pixels and reads
module tb_tia import tia_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINES_PER_FRAME    = 262;
  localparam int FIRST_VISIBLE_LINE = 22;

  logic   clk;
  logic   reset;
  logic   stb;
  logic   we;
  addr_t  adr;
  data_t  dat;
  data_t  dat_o;
  logic   stall_o;
  logic   vid_vsync_o;
  logic   vid_vblank_o;
  logic   vid_wr_o;
  xpos_t  vid_x_o;
  ypos_t  vid_y_o;
  color_t vid_color_o;

  longint limit_ns = 0;  // Set once the frames are counted

  tia_top #(
    .LINES_PER_FRAME(LINES_PER_FRAME),
    .FIRST_VISIBLE_LINE(FIRST_VISIBLE_LINE)
  ) uut (
    .clk, .reset, .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(dat), .dat_o, .stall_o,
    .vid_vsync_o, .vid_vblank_o, .vid_wr_o, .vid_x_o, .vid_y_o, .vid_color_o
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_color(string name, color_t got, color_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp));
  endtask

  task automatic bus_write(addr_t a, data_t d);
    @(posedge clk);
    stb <= 1'b1;
    we  <= 1'b1;
    adr <= a;
    dat <= d;
    @(posedge clk);
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_read(addr_t a, data_t exp);
    @(posedge clk);
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    @(posedge clk);
    stb <= 1'b0;
    @(negedge clk);  // dat_o settled after the sampling edge
    check_data($sformatf("dat_o(read %h)", a), dat_o, exp);
  endtask

  task automatic line_sync();
    bus_write(WSYNC, 8'h00);
    @(negedge clk);
    check_bit("stall_o", stall_o, 1'b1);
    while (stall_o) @(negedge clk);
  endtask

  // VSYNC pulse that restarts the beam, with the level seen on vid_vsync_o
  task automatic frame_restart();
    bus_write(VSYNC, 8'h02);
    @(negedge clk);
    check_bit("vid_vsync_o", vid_vsync_o, 1'b1);
    bus_write(VSYNC, 8'h00);
    @(negedge clk);
    check_bit("vid_vsync_o", vid_vsync_o, 1'b0);
  endtask

  task automatic wait_pixel(xpos_t x, ypos_t y, color_t exp);
    do @(negedge clk); while (!(vid_wr_o && vid_x_o == x && vid_y_o == y));
    check_color($sformatf("vid_color_o(%0d,%0d)", x, y), vid_color_o, exp);
  endtask

  // Ends the run if the stimulus stalls somewhere
  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    fail_run($sformatf("Watchdog timeout after %0d ns, the stimulus did not complete", limit_ns));
  end

  initial begin
    wait (uut.u_assert.fail_count != 0);
    fail_run("A timing assertion on the top level failed");
  end

  initial begin
    int    fd;
    int    n;
    int    frames;
    int    a1;
    int    a2;
    int    a3;
    string line;
    string cmd;
    reset <= 1'b1;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat   <= '0;
    frames = 0;
    fd = $fopen("tia_stimulus.txt", "r");
    if (fd == 0) fail_run("Cannot open tia_stimulus.txt");
    while (!$feof(fd)) begin  // First pass counts frames
      cmd = "";
      n = $fgets(line, fd);
      if (n == 0) break;
      n = $sscanf(line, "%s", cmd);
      if (cmd == "frame") frames++;
    end
    $fclose(fd);
    limit_ns = longint'(frames + 2) * LINES_PER_FRAME * HLINE_CLOCKS * 10;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("stall_o", stall_o, 1'b0);
    check_bit("vid_wr_o", vid_wr_o, 1'b0);
    check_bit("vid_vsync_o", vid_vsync_o, 1'b0);
    check_bit("vid_vblank_o", vid_vblank_o, 1'b0);
    check_data("dat_o", dat_o, 8'h00);
    fd = $fopen("tia_stimulus.txt", "r");
    while (!$feof(fd)) begin
      cmd = "";
      n = $fgets(line, fd);
      if (n == 0) break;
      n = $sscanf(line, "%s", cmd);
      if (cmd == "" || cmd.substr(0, 0) == "#") continue;  // Blank or comment
      if (cmd == "write") begin
        n = $sscanf(line, "%s %h %h", cmd, a1, a2);
        bus_write(addr_t'(a1), data_t'(a2));
      end else if (cmd == "read") begin
        n = $sscanf(line, "%s %h %h", cmd, a1, a2);
        bus_read(addr_t'(a1), data_t'(a2));
      end else if (cmd == "wsync") begin
        line_sync();
      end else if (cmd == "frame") begin
        frame_restart();
      end else if (cmd == "pixel") begin
        n = $sscanf(line, "%s %d %d %h", cmd, a1, a2, a3);
        wait_pixel(xpos_t'(a1), ypos_t'(a2), color_t'(a3));
      end else begin
        fail_run($sformatf("Unknown command in stimulus file: %s", cmd));
      end
    end
    $fclose(fd);
    repeat (4) @(posedge clk);
    if (uut.u_assert.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- tia_stimulus.txt
# Commands: write ADDR DATA | read ADDR EXPECTED | wsync | frame | pixel X Y COLOUR
# ADDR, DATA, EXPECTED and COLOUR are hex, X and Y are decimal
read 00 00
read 01 00
read 02 00
read 03 00
read 04 00
read 05 00
read 06 00
read 07 00
read 0c 00
pixel 10 30 00
# Playfield, normal
write 09 84
write 08 1c
write 0d 10
write 0e 80
write 0f 01
frame
pixel 1 30 0e
pixel 5 30 42
pixel 17 30 0e
pixel 49 30 0e
pixel 81 30 0e
# Playfield, reflected
write 0a 01
frame
pixel 81 30 42
pixel 110 30 0e
pixel 158 30 0e
# Playfield, score colours
write 06 44
write 07 c6
write 0a 02
frame
pixel 1 30 22
pixel 81 30 63
# Players: p0 at 0, p1 at 24 with three close copies
write 0a 00
write 0e 00
write 0f 00
write 1b f0
write 1c 81
write 05 03
wsync
write 10 00
write 11 00
write 21 80
write 2a 00
write 2a 00
write 2a 00
frame
pixel 1 30 22
pixel 5 30 42
pixel 24 30 63
pixel 25 30 42
pixel 31 30 63
pixel 56 30 63
# Playfield priority, p0 double, p1 quad reflected
write 0a 04
write 04 05
write 05 07
write 0c 08
write 1c 01
frame
pixel 1 30 0e
pixel 6 30 22
pixel 9 30 42
pixel 25 30 63
pixel 28 30 42
read 02 80
read 07 00
# Missiles and ball, m1 left disabled
write 0a 30
write 04 10
write 05 20
write 0c 00
write 1c ff
wsync
write 2b 00
write 12 00
write 13 00
write 14 00
write 22 80
write 23 c0
write 24 f0
write 2a 00
write 2a 00
write 2a 00
write 1d 02
write 1f 02
frame
pixel 3 30 0e
pixel 9 30 0e
pixel 13 30 42
pixel 24 30 22
pixel 26 30 63
read 00 80
read 02 c0
read 06 80
# Collision clear inside horizontal blank
wsync
write 2c 00
read 00 00
read 02 00
read 06 00

//--- list.f
tia_pkg.sv
tia_regs.sv
tia_beam.sv
tia_objects.sv
tia_mixer.sv
tia_top.sv
tia_assert.sv
tb_tia.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_tia -o tb_tia_sim &&
  ./obj_dir/tb_tia_sim +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "^Everything OK$" && echo "PASS" ||
  { echo "FAIL"; exit 1; }
